// ==== src/sms_pkg.sv ====
package sms_pkg;

  // ====================================================================
  // Bus and address widths
  // ====================================================================
  localparam int ADDR_W      = 16;  // Z80 address
  localparam int DATA_W      = 8;
  localparam int ROM_ADDR_W  = 24;  // Mapped cartridge address
  localparam int VRAM_ADDR_W = 14;

  // CPU clock enable divider
  localparam int CLK_DIV      = 7;
  localparam int CLK_CNT_W    = $clog2(CLK_DIV);
  localparam int CLK_EN_START = CLK_DIV / 2 + 1;  // Count where enable rises

  // Memory mapper
  localparam int                SLOT_COUNT     = 3;
  localparam logic [DATA_W-1:0] MEM_CTRL_RESET = 8'hF7;  // Bit 3 low selects BIOS
  localparam logic [ADDR_W-1:0] SLOT_BASE      = 16'hFFFD;

  // VDP registers and status
  localparam int                VDP_REG_COUNT = 11;
  localparam logic [DATA_W-1:0] VDP_REG_RESET = 8'h00;
  localparam int                SPRITE_X_W    = 5;
  localparam logic [SPRITE_X_W-1:0] SPRITE_X_NONE = 5'b11111;

  // I/O port classes, encoded as {addr[7:6], addr[0]}
  typedef enum logic [2:0] {
    IO_MEM_CTRL = 3'b000,
    IO_JOY_CTRL = 3'b001,
    IO_V_COUNT  = 3'b010,
    IO_H_COUNT  = 3'b011,  // PSG write shares this class
    IO_VDP_DATA = 3'b100,
    IO_VDP_CTRL = 3'b101,
    IO_JOY_A    = 3'b110,
    IO_JOY_B    = 3'b111
  } io_port_t;

  // Mode number 0 to 4
  typedef logic [2:0] vdp_mode_t;

  function automatic io_port_t io_port_of(input logic [ADDR_W-1:0] addr);
    return io_port_t'({addr[7:6], addr[0]});
  endfunction

endpackage

// ==== src/cpu_bus_if.sv ====
// Decoded Z80 bus, shared by all peripherals
interface cpu_bus_if import sms_pkg::*; ();

  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              io_rd;     // Active-high levels for the whole cycle
  logic              io_wr;
  logic              mem_rd;
  logic              mem_wr;
  logic              cpu_edge;  // One cpuClock wide

  modport sequencer (
    output addr, wdata, io_rd, io_wr, mem_rd, mem_wr, cpu_edge
  );

  modport peripheral (
    input addr, wdata, io_rd, io_wr, mem_rd, mem_wr, cpu_edge
  );

endinterface

// ==== src/cpu_bus_sequencer.sv ====
module cpu_bus_sequencer import sms_pkg::*; (
  input  logic              i_clk,
  input  logic              i_n_hard_reset,
  input  logic [ADDR_W-1:0] i_cpu_addr,
  input  logic [DATA_W-1:0] i_cpu_data,
  input  logic              i_n_rd,
  input  logic              i_n_wr,
  input  logic              i_n_mreq,
  input  logic              i_n_iorq,
  output logic              o_cpu_clk_en,
  cpu_bus_if.sequencer      bus
);

  logic [CLK_CNT_W-1:0] clk_cnt;

  // Divide by CLK_DIV, count wraps after CLK_DIV-1
  always_ff @(posedge i_clk) begin
    if (!i_n_hard_reset) begin
      clk_cnt <= '0;
    end else if (clk_cnt == CLK_CNT_W'(CLK_DIV - 1)) begin
      clk_cnt <= '0;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  assign o_cpu_clk_en = clk_cnt >= CLK_CNT_W'(CLK_EN_START);  // 3 high, 4 low
  assign bus.cpu_edge = clk_cnt == CLK_CNT_W'(CLK_EN_START);  // First high cycle

  // Strobes are active high from here on
  assign bus.io_rd  = !i_n_rd && !i_n_iorq;
  assign bus.io_wr  = !i_n_wr && !i_n_iorq;
  assign bus.mem_rd = !i_n_rd && !i_n_mreq;
  assign bus.mem_wr = !i_n_wr && !i_n_mreq;

  assign bus.addr  = i_cpu_addr;
  assign bus.wdata = i_cpu_data;

endmodule

// ==== src/memory_mapper.sv ====
module memory_mapper import sms_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_n_hard_reset,
  cpu_bus_if.peripheral         bus,
  input  logic [DATA_W-1:0]     i_ram_data,
  input  logic [DATA_W-1:0]     i_bios_data,
  input  logic [DATA_W-1:0]     i_rom_data,
  output logic [ROM_ADDR_W-1:0] o_rom_addr,
  output logic                  o_ram_we,
  output logic [DATA_W-1:0]     o_mem_data
);

  logic [DATA_W-1:0] slot [SLOT_COUNT];
  logic [DATA_W-1:0] mem_ctrl;
  logic [1:0]        region;
  logic [1:0]        slot_offset;
  logic              slot_wr;
  logic              ctrl_wr;

  assign region      = bus.addr[15:14];
  assign slot_offset = bus.addr[1:0] - SLOT_BASE[1:0];
  assign slot_wr     = bus.mem_wr && (bus.addr >= SLOT_BASE);
  assign ctrl_wr     = bus.io_wr && (io_port_of(bus.addr) == IO_MEM_CTRL);

  // ====================================================================
  // Slot and memory-control registers
  // ====================================================================
  always_ff @(posedge i_clk) begin
    if (!i_n_hard_reset) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        slot[i] <= DATA_W'(i);  // Identity mapping of the first 48K
      end
      mem_ctrl <= MEM_CTRL_RESET;
    end else if (bus.cpu_edge) begin
      if (slot_wr) begin
        slot[slot_offset] <= bus.wdata;  // FFFD..FFFF
      end
      if (ctrl_wr) begin
        mem_ctrl <= bus.wdata;
      end
    end
  end

  // Region 3 is RAM, passed through unmapped
  assign o_rom_addr = (region == 2'd3) ? ROM_ADDR_W'(bus.addr)
                                       : ROM_ADDR_W'({slot[region], bus.addr[13:0]});

  assign o_ram_we = bus.mem_wr && (region == 2'd3);

  always_comb begin
    if (bus.mem_rd && region != 2'd3) begin
      o_mem_data = mem_ctrl[3] ? i_rom_data : i_bios_data;  // Bit 3 set once BIOS is done
    end else begin
      o_mem_data = i_ram_data;
    end
  end

endmodule

// ==== src/vdp_port.sv ====
module vdp_port import sms_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_n_hard_reset,
  cpu_bus_if.peripheral          bus,
  input  logic                   i_frame_int,
  input  logic                   i_sprite_collision,
  input  logic                   i_too_many_sprites,
  input  logic [SPRITE_X_W-1:0]  i_sprite_x,
  output logic [VRAM_ADDR_W-1:0] o_vram_addr,
  output logic                   o_vram_wr,
  output logic                   o_vram_rd,
  output logic                   o_cram_sel,
  output vdp_mode_t              o_mode,
  output logic [VRAM_ADDR_W-1:0] o_name_base,
  output logic [VRAM_ADDR_W-1:0] o_color_base,
  output logic [VRAM_ADDR_W-1:0] o_pattern_base,
  output logic [VRAM_ADDR_W-1:0] o_sprite_attr_base,
  output logic [VRAM_ADDR_W-1:0] o_sprite_pattern_base,
  output logic [3:0]             o_backdrop_color,
  output logic [DATA_W-1:0]      o_x_scroll,
  output logic [DATA_W-1:0]      o_y_scroll,
  output logic [DATA_W-1:0]      o_line_count,
  output logic                   o_video_on,
  output logic                   o_frame_int_en,
  output logic                   o_sprite_large,
  output logic                   o_sprite_zoom,
  output logic [DATA_W-1:0]      o_status
);

  logic [DATA_W-1:0] vdp_reg [VDP_REG_COUNT];
  logic [DATA_W-1:0] first_byte;   // Held until the second control byte
  logic              second_byte;
  logic              data_rd_q;
  logic              status_rd_q;
  logic              int_flag;
  logic              coll_flag;
  logic              data_wr, data_rd, ctrl_wr, ctrl_rd;
  vdp_mode_t         mode;

  assign data_wr = bus.io_wr && (io_port_of(bus.addr) == IO_VDP_DATA);
  assign data_rd = bus.io_rd && (io_port_of(bus.addr) == IO_VDP_DATA);
  assign ctrl_wr = bus.io_wr && (io_port_of(bus.addr) == IO_VDP_CTRL);
  assign ctrl_rd = bus.io_rd && (io_port_of(bus.addr) == IO_VDP_CTRL);

  assign o_vram_wr = data_wr && bus.cpu_edge;
  assign o_vram_rd = data_rd && bus.cpu_edge;

  // ====================================================================
  // Control and data port
  // ====================================================================
  always_ff @(posedge i_clk) begin
    if (!i_n_hard_reset) begin
      o_vram_addr <= '0;
      o_cram_sel  <= 1'b0;
      second_byte <= 1'b0;
      data_rd_q   <= 1'b0;
      for (int i = 0; i < VDP_REG_COUNT; i++) begin
        vdp_reg[i] <= VDP_REG_RESET;
      end
    end else if (bus.cpu_edge) begin
      data_rd_q <= data_rd;
      // Read increments once the read cycle is over
      if (data_wr || (data_rd_q && !data_rd)) begin
        o_vram_addr <= o_vram_addr + 1'b1;
      end
      if (ctrl_rd || data_rd || data_wr) begin
        second_byte <= 1'b0;
      end
      if (ctrl_wr) begin
        second_byte <= !second_byte;
        if (!second_byte) begin
          first_byte <= bus.wdata;
        end else if (!bus.wdata[7]) begin  // VRAM address, bit 6 ignored
          o_vram_addr <= {bus.wdata[5:0], first_byte};
          o_cram_sel  <= 1'b0;
        end else if (bus.wdata[7:6] == 2'd2 && bus.wdata[3:0] < VDP_REG_COUNT) begin
          vdp_reg[bus.wdata[3:0]] <= first_byte;
        end else begin
          o_vram_addr <= VRAM_ADDR_W'(first_byte[5:0]);  // CRAM index
          o_cram_sel  <= 1'b1;
        end
      end
    end
  end

  // Sticky flags, cleared after a status read ends
  always_ff @(posedge i_clk) begin
    if (!i_n_hard_reset) begin
      int_flag    <= 1'b0;
      coll_flag   <= 1'b0;
      status_rd_q <= 1'b0;
    end else begin
      if (i_frame_int) int_flag <= 1'b1;
      if (i_sprite_collision) coll_flag <= 1'b1;
      if (bus.cpu_edge) begin
        status_rd_q <= ctrl_rd;
        if (status_rd_q && !ctrl_rd) begin
          int_flag  <= 1'b0;
          coll_flag <= 1'b0;
        end
      end
    end
  end

  assign o_status = {int_flag, i_too_many_sprites, coll_flag,
                     i_too_many_sprites ? i_sprite_x : SPRITE_X_NONE};

  // ====================================================================
  // Mode and table decode
  // ====================================================================
  assign mode = vdp_reg[0][2] ? 3'd4 :  // M4
                vdp_reg[1][3] ? 3'd3 :  // M3
                vdp_reg[0][1] ? 3'd2 :  // M2
                vdp_reg[1][4] ? 3'd1 : 3'd0;
  assign o_mode = mode;

  assign o_name_base        = {vdp_reg[2][3:1], 11'b0};
  assign o_color_base       = (mode == 3'd2) ? {vdp_reg[3][7], 13'b0} : {vdp_reg[3], 6'b0};
  assign o_pattern_base     = (mode == 3'd4) ? '0 :
                              (mode == 3'd2) ? {vdp_reg[4][2], 13'b0} :
                                               {vdp_reg[4][2:0], 11'b0};
  assign o_sprite_attr_base = {vdp_reg[5][6:1], 8'b0};
  assign o_sprite_pattern_base = (mode == 3'd4) ? {vdp_reg[6][2], 13'b0}
                                                : {vdp_reg[6][2:0], 11'b0};

  assign o_backdrop_color = vdp_reg[7][3:0];
  assign o_x_scroll       = vdp_reg[8];
  assign o_y_scroll       = vdp_reg[9];
  assign o_line_count     = vdp_reg[10];
  assign o_video_on       = vdp_reg[1][6];
  assign o_frame_int_en   = vdp_reg[1][5];
  assign o_sprite_large   = vdp_reg[1][1];  // 16 pixel sprites
  assign o_sprite_zoom    = vdp_reg[1][0];

endmodule

// ==== src/cpu_read_mux.sv ====
module cpu_read_mux import sms_pkg::*; (
  input  logic              i_clk,
  cpu_bus_if.peripheral     bus,
  input  logic [6:0]        i_buttons,
  input  logic [DATA_W-1:0] i_vram_data,
  input  logic [DATA_W-1:0] i_status,
  input  logic [DATA_W-1:0] i_v_counter,
  input  logic [DATA_W-1:0] i_h_counter,
  input  logic [DATA_W-1:0] i_mem_data,
  output logic [DATA_W-1:0] o_cpu_data_in
);

  logic [6:1]        buttons_q;  // Button 0 is the board reset
  logic [DATA_W-1:0] joy_data;

  always_ff @(posedge i_clk) begin
    buttons_q <= i_buttons[6:1];
  end

  // Joypad lines are active low
  assign joy_data = {2'b00, ~buttons_q[2:1], ~buttons_q[6:3]};

  always_comb begin
    o_cpu_data_in = i_mem_data;
    if (bus.io_rd) begin
      case (io_port_of(bus.addr))
        IO_VDP_DATA:        o_cpu_data_in = i_vram_data;
        IO_VDP_CTRL:        o_cpu_data_in = i_status;
        IO_JOY_A, IO_JOY_B: o_cpu_data_in = joy_data;  // Both pads read the same
        IO_V_COUNT:         o_cpu_data_in = i_v_counter;
        IO_H_COUNT:         o_cpu_data_in = i_h_counter;
        default:            o_cpu_data_in = i_mem_data;
      endcase
    end
  end

endmodule

// ==== src/sms_chipset.sv ====
module sms_chipset import sms_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_n_hard_reset,
  // Z80 bus
  input  logic [ADDR_W-1:0]      i_cpu_addr,
  input  logic [DATA_W-1:0]      i_cpu_data,
  input  logic                   i_n_rd,
  input  logic                   i_n_wr,
  input  logic                   i_n_mreq,
  input  logic                   i_n_iorq,
  output logic                   o_cpu_clk_en,
  output logic [DATA_W-1:0]      o_cpu_data_in,
  // Memories
  input  logic [DATA_W-1:0]      i_ram_data,
  input  logic [DATA_W-1:0]      i_bios_data,
  input  logic [DATA_W-1:0]      i_rom_data,
  output logic [ROM_ADDR_W-1:0]  o_rom_addr,
  output logic                   o_ram_we,
  // Inputs from the pads and the renderer
  input  logic [6:0]             i_buttons,
  input  logic [DATA_W-1:0]      i_vram_data,
  input  logic [DATA_W-1:0]      i_h_counter,
  input  logic [DATA_W-1:0]      i_v_counter,
  input  logic                   i_frame_int,
  input  logic                   i_sprite_collision,
  input  logic                   i_too_many_sprites,
  input  logic [SPRITE_X_W-1:0]  i_sprite_x,
  // Renderer control
  output logic [VRAM_ADDR_W-1:0] o_vram_addr,
  output logic                   o_vram_wr,
  output logic                   o_vram_rd,
  output logic                   o_cram_sel,
  output vdp_mode_t              o_mode,
  output logic [VRAM_ADDR_W-1:0] o_name_base,
  output logic [VRAM_ADDR_W-1:0] o_color_base,
  output logic [VRAM_ADDR_W-1:0] o_pattern_base,
  output logic [VRAM_ADDR_W-1:0] o_sprite_attr_base,
  output logic [VRAM_ADDR_W-1:0] o_sprite_pattern_base,
  output logic [3:0]             o_backdrop_color,
  output logic [DATA_W-1:0]      o_x_scroll,
  output logic [DATA_W-1:0]      o_y_scroll,
  output logic [DATA_W-1:0]      o_line_count,
  output logic                   o_video_on,
  output logic                   o_frame_int_en,
  output logic                   o_sprite_large,
  output logic                   o_sprite_zoom,
  output logic [DATA_W-1:0]      o_status
);

  logic [DATA_W-1:0] mem_data;

  cpu_bus_if bus ();

  cpu_bus_sequencer u_sequencer (
    .i_clk(i_clk), .i_n_hard_reset(i_n_hard_reset),
    .i_cpu_addr(i_cpu_addr), .i_cpu_data(i_cpu_data),
    .i_n_rd(i_n_rd), .i_n_wr(i_n_wr), .i_n_mreq(i_n_mreq), .i_n_iorq(i_n_iorq),
    .o_cpu_clk_en(o_cpu_clk_en), .bus(bus.sequencer)
  );

  memory_mapper u_mapper (
    .i_clk(i_clk), .i_n_hard_reset(i_n_hard_reset), .bus(bus.peripheral),
    .i_ram_data(i_ram_data), .i_bios_data(i_bios_data), .i_rom_data(i_rom_data),
    .o_rom_addr(o_rom_addr), .o_ram_we(o_ram_we), .o_mem_data(mem_data)
  );

  vdp_port u_vdp (
    .i_clk(i_clk), .i_n_hard_reset(i_n_hard_reset), .bus(bus.peripheral),
    .i_frame_int(i_frame_int), .i_sprite_collision(i_sprite_collision),
    .i_too_many_sprites(i_too_many_sprites), .i_sprite_x(i_sprite_x),
    .o_vram_addr(o_vram_addr), .o_vram_wr(o_vram_wr), .o_vram_rd(o_vram_rd),
    .o_cram_sel(o_cram_sel), .o_mode(o_mode),
    .o_name_base(o_name_base), .o_color_base(o_color_base),
    .o_pattern_base(o_pattern_base), .o_sprite_attr_base(o_sprite_attr_base),
    .o_sprite_pattern_base(o_sprite_pattern_base),
    .o_backdrop_color(o_backdrop_color), .o_x_scroll(o_x_scroll),
    .o_y_scroll(o_y_scroll), .o_line_count(o_line_count),
    .o_video_on(o_video_on), .o_frame_int_en(o_frame_int_en),
    .o_sprite_large(o_sprite_large), .o_sprite_zoom(o_sprite_zoom),
    .o_status(o_status)
  );

  cpu_read_mux u_read_mux (
    .i_clk(i_clk), .bus(bus.peripheral), .i_buttons(i_buttons),
    .i_vram_data(i_vram_data), .i_status(o_status),
    .i_v_counter(i_v_counter), .i_h_counter(i_h_counter),
    .i_mem_data(mem_data), .o_cpu_data_in(o_cpu_data_in)
  );

endmodule

// ==== sim/sms_chipset_props.sv ====
module sms_chipset_props import sms_pkg::*; (
  input logic              i_clk,
  input logic              i_n_hard_reset,
  input logic [ADDR_W-1:0] i_cpu_addr,
  input logic              o_cpu_clk_en,
  input logic              o_vram_wr,
  input logic              o_vram_rd,
  input logic              o_ram_we
);
  timeunit 1ns;
  timeprecision 100ps;

  // ====================================================================
  // CPU clock enable, 3 high and 4 low
  // ====================================================================
  clk_en_period: assert property (@(posedge i_clk) disable iff (!i_n_hard_reset)
    $rose(o_cpu_clk_en) |-> ##7 $rose(o_cpu_clk_en))
    else $error("CPU clock enable did not repeat after seven cycles");

  clk_en_high: assert property (@(posedge i_clk) disable iff (!i_n_hard_reset)
    $rose(o_cpu_clk_en) |-> ##3 $fell(o_cpu_clk_en))
    else $error("CPU clock enable was not high for three cycles");

  clk_en_low: assert property (@(posedge i_clk) disable iff (!i_n_hard_reset)
    $fell(o_cpu_clk_en) |-> ##4 $rose(o_cpu_clk_en))
    else $error("CPU clock enable was not low for four cycles");

  // VRAM strobes
  vram_exclusive: assert property (@(posedge i_clk) disable iff (!i_n_hard_reset)
    !(o_vram_wr && o_vram_rd))
    else $error("VRAM write and read strobes were high together");

  vram_wr_single: assert property (@(posedge i_clk) disable iff (!i_n_hard_reset)
    o_vram_wr |=> !o_vram_wr)
    else $error("VRAM write strobe lasted more than one cycle");

  vram_rd_single: assert property (@(posedge i_clk) disable iff (!i_n_hard_reset)
    o_vram_rd |=> !o_vram_rd)
    else $error("VRAM read strobe lasted more than one cycle");

  ram_we_region: assert property (@(posedge i_clk) disable iff (!i_n_hard_reset)
    o_ram_we |-> i_cpu_addr[15:14] == 2'b11)
    else $error("RAM write enable raised outside the RAM region");

endmodule

// ==== sim/tb_sms_chipset.sv ====
module tb_sms_chipset import sms_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 3000;  // ~95 accesses of 14 cycles, doubled
  localparam logic [DATA_W-1:0] BIOS_BYTE = 8'hB1;
  localparam logic [DATA_W-1:0] ROM_BYTE  = 8'hC2;
  localparam logic [DATA_W-1:0] RAM_BYTE  = 8'hA3;
  localparam logic [DATA_W-1:0] VRAM_BYTE = 8'h5D;
  localparam logic [ADDR_W-1:0] MEM_CTRL_PORT = 16'h003E;
  localparam logic [ADDR_W-1:0] VDP_DATA_PORT = 16'h00BE;
  localparam logic [ADDR_W-1:0] VDP_CTRL_PORT = 16'h00BF;

  logic                   cpuClock;
  logic                   n_hard_reset;
  logic [ADDR_W-1:0]      i_cpu_addr;
  logic [DATA_W-1:0]      i_cpu_data;
  logic                   i_n_rd, i_n_wr, i_n_mreq, i_n_iorq;
  logic [DATA_W-1:0]      i_ram_data, i_bios_data, i_rom_data, i_vram_data;
  logic [6:0]             i_buttons;
  logic [DATA_W-1:0]      i_h_counter, i_v_counter;
  logic                   i_frame_int, i_sprite_collision, i_too_many_sprites;
  logic [SPRITE_X_W-1:0]  i_sprite_x;
  logic                   o_cpu_clk_en, o_ram_we, o_vram_wr, o_vram_rd, o_cram_sel;
  logic [DATA_W-1:0]      o_cpu_data_in, o_status;
  logic [ROM_ADDR_W-1:0]  o_rom_addr;
  logic [VRAM_ADDR_W-1:0] o_vram_addr, o_name_base, o_color_base, o_pattern_base;
  logic [VRAM_ADDR_W-1:0] o_sprite_attr_base, o_sprite_pattern_base;
  vdp_mode_t              o_mode;
  logic [3:0]             o_backdrop_color;
  logic [DATA_W-1:0]      o_x_scroll, o_y_scroll, o_line_count;
  logic                   o_video_on, o_frame_int_en, o_sprite_large, o_sprite_zoom;

  logic [7:0]             lfsr = 8'd11;
  logic [7:0]             regs [VDP_REG_COUNT];  // Shadow of the VDP registers
  logic [7:0]             seen_data;             // Snapshots taken inside a bus cycle
  logic [ROM_ADDR_W-1:0]  seen_rom_addr;
  logic                   seen_ram_we;
  logic [VRAM_ADDR_W-1:0] seen_vram_addr;
  logic                   seen_cram_sel;
  int                     cycle_count = 0;
  int                     wr_pulses = 0;
  int                     rd_pulses = 0;
  int                     checks = 0;
  int                     errors = 0;
  int                     test_checks, test_errors;

  sms_chipset UUT (.i_clk(cpuClock), .i_n_hard_reset(n_hard_reset), .*);

  bind sms_chipset sms_chipset_props u_props (
    .i_clk(i_clk), .i_n_hard_reset(i_n_hard_reset), .i_cpu_addr(i_cpu_addr),
    .o_cpu_clk_en(o_cpu_clk_en), .o_vram_wr(o_vram_wr), .o_vram_rd(o_vram_rd),
    .o_ram_we(o_ram_we)
  );

  initial begin
    cpuClock = 1'b0;
    forever #2 cpuClock = ~cpuClock;
  end

  always @(posedge cpuClock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Count VRAM strobes
  always @(negedge cpuClock) begin
    if (o_vram_wr) wr_pulses <= wr_pulses + 1;
    if (o_vram_rd) rd_pulses <= rd_pulses + 1;
  end

  // ====================================================================
  // Helpers
  // ====================================================================
  function automatic logic [7:0] lfsr_step(input logic [7:0] state);
    return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};  // x^8+x^6+x^5+x^4+1
  endfunction

  task automatic take_random(input int nbits, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_step(lfsr);
      value = {value[6:0], lfsr[0]};
    end
  endtask

  task automatic check(input string name, input logic [23:0] exp, input logic [23:0] act);
    checks++;
    test_checks++;
    assert (act === exp) else begin
      errors++;
      test_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic begin_test();
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test(input string name);
    $display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
  endtask

  // Waits until the enable-low phase after the next CPU edge begins
  task automatic wait_period();
    do @(negedge cpuClock); while (!o_cpu_clk_en);
    do @(negedge cpuClock); while (o_cpu_clk_en);
  endtask

  // One access held for a full enable period, then released before the next edge
  task automatic bus_cycle(input logic is_io, input logic is_wr,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    wait_period();
    @(posedge cpuClock);
    i_cpu_addr <= addr;
    i_cpu_data <= wdata;
    i_n_iorq   <= !is_io;
    i_n_mreq   <= is_io;
    i_n_wr     <= !is_wr;
    i_n_rd     <= is_wr;
    repeat (CLK_DIV - 1) @(posedge cpuClock);
    @(negedge cpuClock);
    seen_data      = o_cpu_data_in;
    seen_rom_addr  = o_rom_addr;
    seen_ram_we    = o_ram_we;
    seen_vram_addr = o_vram_addr;
    seen_cram_sel  = o_cram_sel;
    @(posedge cpuClock);
    i_n_rd   <= 1'b1;
    i_n_wr   <= 1'b1;
    i_n_mreq <= 1'b1;
    i_n_iorq <= 1'b1;
  endtask

  task automatic check_registers();
    vdp_mode_t mode;
    @(negedge cpuClock);
    mode = regs[0][2] ? 3'd4 :
           regs[1][3] ? 3'd3 :
           regs[0][1] ? 3'd2 :
           regs[1][4] ? 3'd1 : 3'd0;
    check("mode", 24'(mode), 24'(o_mode));
    check("name base", 24'(regs[2][3:1]) * 24'h800, 24'(o_name_base));
    check("color base", (mode == 3'd2) ? 24'(regs[3][7]) * 24'h2000 : 24'(regs[3]) * 24'd64,
          24'(o_color_base));
    check("pattern base", (mode == 3'd4) ? 24'h0 :
          (mode == 3'd2) ? 24'(regs[4][2]) * 24'h2000 : (24'(regs[4]) * 24'h800) & 24'h3FFF,
          24'(o_pattern_base));
    check("sprite attr base", 24'(regs[5][6:1]) * 24'h100, 24'(o_sprite_attr_base));
    check("sprite pattern base", (mode == 3'd4) ? 24'(regs[6][2]) * 24'h2000
          : 24'(regs[6][2:0]) * 24'h800, 24'(o_sprite_pattern_base));
    check("backdrop", 24'(regs[7][3:0]), 24'(o_backdrop_color));
    check("x scroll", 24'(regs[8]), 24'(o_x_scroll));
    check("y scroll", 24'(regs[9]), 24'(o_y_scroll));
    check("line count", 24'(regs[10]), 24'(o_line_count));
    check("display flags", 24'({regs[1][6], regs[1][5], regs[1][1], regs[1][0]}),
          24'({o_video_on, o_frame_int_en, o_sprite_large, o_sprite_zoom}));
  endtask

  // ====================================================================
  // Tests
  // ====================================================================
  initial begin
    logic [7:0]             value;
    logic [7:0]             lo;
    logic [7:0]             hi;
    logic [VRAM_ADDR_W-1:0] exp_vram;
    n_hard_reset       = 1'b0;
    i_cpu_addr         = '0;
    i_cpu_data         = '0;
    i_n_rd             = 1'b1;
    i_n_wr             = 1'b1;
    i_n_mreq           = 1'b1;
    i_n_iorq           = 1'b1;
    i_ram_data         = RAM_BYTE;
    i_bios_data        = BIOS_BYTE;
    i_rom_data         = ROM_BYTE;
    i_vram_data        = VRAM_BYTE;
    i_buttons          = '0;
    i_h_counter        = '0;
    i_v_counter        = '0;
    i_frame_int        = 1'b0;
    i_sprite_collision = 1'b0;
    i_too_many_sprites = 1'b0;
    i_sprite_x         = '0;
    repeat (3) @(posedge cpuClock);
    n_hard_reset <= 1'b1;

    begin_test();
    bus_cycle(1'b0, 1'b0, 16'h4123, 8'h00);
    // Slot 1 holds bank 1 of 16K, offset from address bits 13:0
    check("reset rom addr", 24'd1 * 24'h4000 + 24'h0123, seen_rom_addr);
    check("reset bios read", 24'(BIOS_BYTE), 24'(seen_data));
    check("reset ram we", 24'h0, 24'(seen_ram_we));
    check("reset vram wr", 24'h0, 24'(wr_pulses));
    end_test("reset");

    begin_test();
    for (int k = 0; k < 3; k++) begin
      take_random(8, value);
      bus_cycle(1'b0, 1'b1, SLOT_BASE + 16'(k), value);
      bus_cycle(1'b0, 1'b0, {2'(k), 14'h0ABC}, 8'h00);
      check("slot rom addr", 24'(value) * 24'h4000 + 24'h0ABC, seen_rom_addr);
    end
    bus_cycle(1'b1, 1'b1, MEM_CTRL_PORT, 8'h08);
    bus_cycle(1'b0, 1'b0, 16'h0100, 8'h00);
    check("rom read", 24'(ROM_BYTE), 24'(seen_data));
    take_random(8, value);
    bus_cycle(1'b0, 1'b1, 16'hC000, value);
    check("ram we", 24'h1, 24'(seen_ram_we));
    check("ram rom addr", 24'h00C000, seen_rom_addr);
    bus_cycle(1'b0, 1'b0, 16'hC000, 8'h00);
    check("ram read", 24'(RAM_BYTE), 24'(seen_data));
    end_test("mapper");

    begin_test();
    take_random(8, lo);
    take_random(6, hi);
    bus_cycle(1'b1, 1'b1, VDP_CTRL_PORT, lo);
    bus_cycle(1'b1, 1'b1, VDP_CTRL_PORT, {2'b01, hi[5:0]});
    exp_vram = {hi[5:0], lo};
    check("vram addr", 24'(exp_vram), 24'(seen_vram_addr));
    for (int n = 0; n < 2; n++) begin
      take_random(8, value);
      bus_cycle(1'b1, 1'b1, VDP_DATA_PORT, value);
      exp_vram = exp_vram + 1'b1;
      check("write increment", 24'(exp_vram), 24'(seen_vram_addr));
    end
    check("vram wr pulses", 24'h2, 24'(wr_pulses));
    bus_cycle(1'b1, 1'b0, VDP_DATA_PORT, 8'h00);
    check("vram read", 24'(VRAM_BYTE), 24'(seen_data));
    check("addr during read", 24'(exp_vram), 24'(seen_vram_addr));
    wait_period();
    exp_vram = exp_vram + 1'b1;
    check("read increment", 24'(exp_vram), 24'(o_vram_addr));
    check("vram rd pulses", 24'h1, 24'(rd_pulses));
    take_random(8, lo);
    bus_cycle(1'b1, 1'b1, VDP_CTRL_PORT, lo);
    bus_cycle(1'b1, 1'b1, VDP_CTRL_PORT, 8'hC0);
    check("cram select", 24'h1, 24'(seen_cram_sel));
    check("cram addr", 24'(lo[5:0]), 24'(seen_vram_addr));
    end_test("vdp port");

    begin_test();
    for (int round = 0; round < 3; round++) begin
      for (int r = 0; r < VDP_REG_COUNT; r++) begin
        take_random(8, regs[r]);
        bus_cycle(1'b1, 1'b1, VDP_CTRL_PORT, regs[r]);
        bus_cycle(1'b1, 1'b1, VDP_CTRL_PORT, 8'h80 | 8'(r));
      end
      check_registers();
    end
    bus_cycle(1'b1, 1'b1, VDP_CTRL_PORT, 8'h00);  // Back to VRAM first
    bus_cycle(1'b1, 1'b1, VDP_CTRL_PORT, 8'h40);
    check("vram select", 24'h0, 24'(seen_cram_sel));
    take_random(8, lo);
    take_random(2, hi);
    bus_cycle(1'b1, 1'b1, VDP_CTRL_PORT, lo);
    bus_cycle(1'b1, 1'b1, VDP_CTRL_PORT, 8'h8B + hi);  // Index 11 to 14
    check("high index cram", 24'h1, 24'(seen_cram_sel));
    check("high index addr", 24'(lo[5:0]), 24'(seen_vram_addr));
    check("high index x scroll", 24'(regs[8]), 24'(o_x_scroll));
    end_test("vdp registers");

    begin_test();
    @(posedge cpuClock);
    i_frame_int        <= 1'b1;
    i_sprite_collision <= 1'b1;
    @(posedge cpuClock);
    i_frame_int        <= 1'b0;
    i_sprite_collision <= 1'b0;
    @(negedge cpuClock);
    check("status output", 24'hBF, 24'(o_status));
    bus_cycle(1'b1, 1'b0, VDP_CTRL_PORT, 8'h00);
    check("status set", 24'hBF, 24'(seen_data));
    bus_cycle(1'b1, 1'b0, VDP_CTRL_PORT, 8'h00);
    check("status cleared", 24'h1F, 24'(seen_data));
    take_random(5, value);
    @(posedge cpuClock);
    i_too_many_sprites <= 1'b1;
    i_sprite_x         <= value[4:0];
    bus_cycle(1'b1, 1'b0, VDP_CTRL_PORT, 8'h00);
    check("status sprite x", 24'({3'b010, value[4:0]}), 24'(seen_data));
    take_random(7, value);
    @(posedge cpuClock);
    i_buttons <= value[6:0];
    bus_cycle(1'b1, 1'b0, 16'h00DC, 8'h00);
    check("joypad a", 24'({2'b00, ~value[2:1], ~value[6:3]}), 24'(seen_data));
    bus_cycle(1'b1, 1'b0, 16'h00DD, 8'h00);
    check("joypad b", 24'({2'b00, ~value[2:1], ~value[6:3]}), 24'(seen_data));
    take_random(8, lo);
    take_random(8, hi);
    @(posedge cpuClock);
    i_v_counter <= lo;
    i_h_counter <= hi;
    bus_cycle(1'b1, 1'b0, 16'h007E, 8'h00);
    check("v counter", 24'(lo), 24'(seen_data));
    bus_cycle(1'b1, 1'b0, 16'h007F, 8'h00);
    check("h counter", 24'(hi), 24'(seen_data));
    end_test("status and inputs");

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sms_chipset.f ====
src/sms_pkg.sv
src/cpu_bus_if.sv
src/cpu_bus_sequencer.sv
src/memory_mapper.sv
src/vdp_port.sv
src/cpu_read_mux.sv
src/sms_chipset.sv
sim/sms_chipset_props.sv
sim/tb_sms_chipset.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sms_chipset -f sms_chipset.f -o sim_sms_chipset
./obj_dir/sim_sms_chipset | tee sim.log

grep -qF "*** TEST PASSED ***" sim.log
